/* sim.f */
+incdir+include
verilog/alu_ops_pkg.sv
verilog/rs_types_pkg.sv
verilog/wb_host_port.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/rob_result_buffer.sv
verilog/rs_subsystem_top.sv
tb/rs_subsystem_tb.sv

/* tb/rs_subsystem_golden.txt */
# name op val_i val_j tag_i rdy_i tag_j rdy_j dest expected
# hex fields after the name, a source with rdy 0 takes the result of its tag
add_basic     0 00000005 00000007 0 1 0 1 0 0000000c
sub_wrap      1 00000003 00000005 0 1 0 1 1 fffffffe
and_mask      2 f0f0ff00 0ff00ff0 0 1 0 1 2 00f00f00
or_mix        3 f0000000 0000000f 0 1 0 1 3 f000000f
xor_flip      4 aaaaaaaa ffff0000 0 1 0 1 4 5555aaaa
slt_signed    5 ffffffff 00000001 0 1 0 1 5 00000001
sltu_unsigned 6 ffffffff 00000001 0 1 0 1 6 00000000
dep_buffered  1 00000000 00000000 0 0 5 0 7 0000000b
sll_by31      7 00000001 0000001f 0 1 0 1 0 80000000
srl_by31_dep  8 00000000 0000001f 0 0 0 1 1 00000001
sll_by1_dep   7 00000000 00000001 1 0 0 1 2 00000002
sra_by1_dep   9 80000000 00000000 0 1 1 0 3 c0000000
srl_by1_dep   8 80000000 00000000 0 1 1 0 4 40000000
sra_by0       9 fedcba98 00000000 0 1 0 1 5 fedcba98
sra_by31      9 80000000 ffffffff 0 1 0 1 6 ffffffff
srl_by0       8 87654321 00000020 0 1 0 1 7 87654321
sll_by0       7 0000abcd 00000000 0 1 0 1 0 0000abcd

/* tb/rs_subsystem_tb.sv */
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_subsystem_tb;

  localparam int max_tests       = 32;
  localparam int cycles_per_test = 400;

  logic              clk_in;
  logic              rst_in;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [`WB_AW-1:0] wb_adr;
  logic [`XLEN-1:0]  wb_dat_w;
  logic [`XLEN-1:0]  wb_dat_r;
  logic              wb_ack;

  logic [8*20-1:0]      t_name [max_tests];
  logic [3:0]           t_op [max_tests];
  logic [31:0]          t_val_i [max_tests];
  logic [31:0]          t_val_j [max_tests];
  logic [2:0]           t_tag_i [max_tests];
  logic [2:0]           t_tag_j [max_tests];
  logic                 t_rdy_i [max_tests];
  logic                 t_rdy_j [max_tests];
  logic [2:0]           t_dest [max_tests];
  logic [31:0]          t_exp [max_tests];
  int                   num_tests;
  logic                 loaded;
  int                   checks;
  int                   errors;
  logic [31:0]          lfsr;
  logic [`ROB_TAGS-1:0] in_flight;       // tags dispatched and not yet read back
  int                   line_of_tag [`ROB_TAGS];
  logic                 file_ok;

  rs_subsystem_top rs_subsystem_top_i (
    .clk_in, .rst_in,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  // x^32 + x^22 + x^2 + x + 1, shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic bus_write(input logic [`WB_AW-1:0] adr, input logic [31:0] data);
    @(negedge clk_in);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    do @(negedge clk_in); while (!wb_ack);  // a full station holds the ack back
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [`WB_AW-1:0] adr, output logic [31:0] data);
    @(negedge clk_in);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do @(negedge clk_in); while (!wb_ack);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // 0 to 3 idle cycles, two lfsr bits
  task automatic idle_gap();
    int n;
    n = 0;
    repeat (2) begin
      n    = (n << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
    repeat (n) @(negedge clk_in);
  endtask

  task automatic load_golden(output logic ok);
    int              fd;
    int              n;
    string           line;
    logic [8*20-1:0] name;
    logic [31:0]     op, vi, vj, ti, ri, tj, rj, dst, ex;
    ok = 1'b0;
    fd = $fopen("tb/rs_subsystem_golden.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && num_tests < max_tests) begin
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                             name, op, vi, vj, ti, ri, tj, rj, dst, ex) == 10) begin
          t_name[num_tests]  = name;
          t_op[num_tests]    = op[3:0];
          t_val_i[num_tests] = vi;
          t_val_j[num_tests] = vj;
          t_tag_i[num_tests] = ti[2:0];
          t_rdy_i[num_tests] = ri[0];
          t_tag_j[num_tests] = tj[2:0];
          t_rdy_j[num_tests] = rj[0];
          t_dest[num_tests]  = dst[2:0];
          t_exp[num_tests]   = ex;
          num_tests++;
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  task automatic dispatch_line(input int k);
    logic [31:0] word;
    word = {16'd0, t_rdy_j[k], t_tag_j[k], t_rdy_i[k], t_tag_i[k], 1'b0, t_dest[k], t_op[k]};
    idle_gap();
    bus_write(`WB_AW'(0), t_val_i[k]);
    bus_write(`WB_AW'(1), t_val_j[k]);
    bus_write(`WB_AW'(2), word);  // acked once the station takes it
  endtask

  // results come back by tag, whatever order they finished in
  task automatic collect_results();
    logic [31:0] rd;
    int          k;
    for (int t = 0; t < `ROB_TAGS; t++) begin
      if (in_flight[t]) begin
        k = line_of_tag[t];
        bus_write(`WB_AW'(3), 32'(t));
        do bus_read(`WB_AW'(5), rd); while (rd[0] !== 1'b1);
        bus_read(`WB_AW'(4), rd);
        checks++;
        if (rd !== t_exp[k]) begin
          errors++;
          $display("error %0s result expected %h actual %h", t_name[k], t_exp[k], rd);
        end
        bus_read(`WB_AW'(5), rd);  // slot was freed by the result read
        checks++;
        if (rd !== 32'd0) begin
          errors++;
          $display("error %0s freed_done expected %h actual %h", t_name[k], 32'd0, rd);
        end
      end
    end
    in_flight = '0;
  endtask

  initial begin
    rst_in    = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    checks    = 0;
    errors    = 0;
    num_tests = 0;
    loaded    = 1'b0;
    in_flight = '0;
    lfsr      = 32'hb92d;
    load_golden(file_ok);
    if (!file_ok) begin
      $display("could not open tb/rs_subsystem_golden.txt");
      $display("*** FAILED ***");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (5) @(posedge clk_in);
      @(negedge clk_in);
      rst_in = 1'b0;
      for (int k = 0; k < num_tests; k++) begin
        if (in_flight[t_dest[k]]) collect_results();  // tag reuse waits for the old slot
        dispatch_line(k);
        in_flight[t_dest[k]] = 1'b1;
        line_of_tag[t_dest[k]] = k;
      end
      collect_results();
      $display("tests %0d checks %0d errors %0d", num_tests, checks, errors);
      if (errors == 0 && num_tests > 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

  initial begin
    wait (loaded);
    repeat (num_tests * cycles_per_test) @(posedge clk_in);
    $display("timeout after %0d cycles, a result never arrived", num_tests * cycles_per_test);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verilog/rs_subsystem_top.sv */
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_subsystem_top
  import rs_types_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [`WB_AW-1:0] wb_adr,
  input  logic [`XLEN-1:0]  wb_dat_w,
  output logic [`XLEN-1:0]  wb_dat_r,
  output logic              wb_ack
);

  logic              rs_free;
  logic              dispatch_valid;
  dispatch_t         dispatch;
  logic [`TAG_W-1:0] lookup_tag_i;
  logic [`TAG_W-1:0] lookup_tag_j;
  tag_lookup_t       lookup_i;
  tag_lookup_t       lookup_j;
  logic [`TAG_W-1:0] read_tag;
  tag_lookup_t       read_result;
  logic              read_free;
  cdb_t              cdb;          // registered broadcast from the result buffer
  cdb_t              alu_result;   // raw alu output, one cycle earlier
  logic              fu_busy;
  logic              issue_valid;
  issue_t            issue;

  wb_host_port wb_host_port_i (
    .clk_in, .rst_in,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .rs_free, .lookup_i, .lookup_j, .lookup_tag_i, .lookup_tag_j,
    .cdb, .dispatch_valid, .dispatch, .read_tag, .read_result, .read_free
  );

  reservation_station reservation_station_i (
    .clk_in, .rst_in,
    .dispatch_valid, .dispatch, .cdb, .fu_busy,
    .rs_free, .issue_valid, .issue
  );

  alu_unit alu_unit_i (
    .clk_in, .rst_in,
    .issue_valid, .issue, .fu_busy,
    .result (alu_result)
  );

  rob_result_buffer rob_result_buffer_i (
    .clk_in, .rst_in,
    .result (alu_result),
    .cdb, .lookup_tag_i, .lookup_tag_j, .read_tag,
    .lookup_i, .lookup_j, .read_result, .read_free
  );

endmodule

/* verilog/rob_result_buffer.sv */
`timescale 1ns/1ps
`include "rs_config.svh"

module rob_result_buffer
  import rs_types_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  cdb_t              result,
  output cdb_t              cdb,
  input  logic [`TAG_W-1:0] lookup_tag_i,
  input  logic [`TAG_W-1:0] lookup_tag_j,
  input  logic [`TAG_W-1:0] read_tag,
  output tag_lookup_t       lookup_i,
  output tag_lookup_t       lookup_j,
  output tag_lookup_t       read_result,
  input  logic              read_free
);

  logic [`ROB_TAGS-1:0] done;
  logic [`XLEN-1:0]     vals [`ROB_TAGS];

  // three independent read ports into the slots
  assign lookup_i.done     = done[lookup_tag_i];
  assign lookup_i.value    = vals[lookup_tag_i];
  assign lookup_j.done     = done[lookup_tag_j];
  assign lookup_j.value    = vals[lookup_tag_j];
  assign read_result.done  = done[read_tag];
  assign read_result.value = vals[read_tag];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      done <= '0;
    end else begin
      if (read_free) done[read_tag] <= 1'b0;  // host has taken the value
      if (result.valid) done[result.tag] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (result.valid) vals[result.tag] <= result.value;
  end

  // broadcast lines up with the slot turning done
  always_ff @(posedge clk_in) begin
    cdb.tag   <= result.tag;
    cdb.value <= result.value;
    if (rst_in) cdb.valid <= 1'b0;
    else cdb.valid <= result.valid;
  end

  // a tag is reused only after the host frees its slot
  a_slot_free: assert property (@(posedge clk_in) disable iff (rst_in)
    result.valid |-> !done[result.tag]);

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ps
`include "rs_config.svh"

module alu_unit
  import alu_ops_pkg::*;
  import rs_types_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   issue_valid,
  input  issue_t issue,
  output logic   fu_busy,
  output cdb_t   result
);

  shift_state_e     state;
  alu_op_e          sh_op;
  logic [`XLEN-1:0] sh_val;
  logic [4:0]       sh_cnt;   // steps still to go
  logic [4:0]       amt;
  logic             is_shift;
  logic [`XLEN-1:0] alu_out;

  function automatic logic [`XLEN-1:0] shift_step(input alu_op_e op, input logic [`XLEN-1:0] v);
    case (op)
      sll:     return {v[`XLEN-2:0], 1'b0};
      srl:     return {1'b0, v[`XLEN-1:1]};
      default: return {v[`XLEN-1], v[`XLEN-1:1]};  // sra keeps the sign
    endcase
  endfunction

  assign amt      = issue.val_j[4:0];
  assign is_shift = issue.op inside {sll, srl, sra};
  assign fu_busy  = (state == shifting) || (issue_valid && is_shift && amt > 5'd1);

  always_comb begin
    case (issue.op)
      add:     alu_out = issue.val_i + issue.val_j;
      sub:     alu_out = issue.val_i - issue.val_j;
      and_op:  alu_out = issue.val_i & issue.val_j;
      or_op:   alu_out = issue.val_i | issue.val_j;
      xor_op:  alu_out = issue.val_i ^ issue.val_j;
      slt:     alu_out = `XLEN'($signed(issue.val_i) < $signed(issue.val_j));
      sltu:    alu_out = `XLEN'(issue.val_i < issue.val_j);
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state        <= idle;
      result.valid <= 1'b0;
    end else begin
      result.valid <= 1'b0;
      case (state)
        idle: if (issue_valid) begin
          result.tag <= issue.tag;  // held here through a long shift
          if (!is_shift) begin
            result.valid <= 1'b1;
            result.value <= alu_out;
          end else if (amt <= 5'd1) begin
            result.valid <= 1'b1;
            result.value <= amt[0] ? shift_step(issue.op, issue.val_i) : issue.val_i;
          end else begin
            sh_op  <= issue.op;
            sh_val <= shift_step(issue.op, issue.val_i);  // first step in the issue cycle
            sh_cnt <= amt - 5'd1;
            state  <= shifting;
          end
        end
        shifting: if (sh_cnt == 5'd1) begin
          result.valid <= 1'b1;
          result.value <= shift_step(sh_op, sh_val);
          state        <= idle;
        end else begin
          sh_val <= shift_step(sh_op, sh_val);
          sh_cnt <= sh_cnt - 5'd1;
        end
        default: state <= idle;
      endcase
    end
  end

  // station must hold off while the shifter runs
  a_no_issue_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    issue_valid |-> state == idle);

endmodule

/* verilog/reservation_station.sv */
`timescale 1ns/1ps
`include "rs_config.svh"

module reservation_station
  import rs_types_pkg::*;
(
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      dispatch_valid,
  input  dispatch_t dispatch,
  input  cdb_t      cdb,
  input  logic      fu_busy,
  output logic      rs_free,
  output logic      issue_valid,
  output issue_t    issue
);

  localparam int idx_w = $clog2(`RS_DEPTH);

  dispatch_t            ent [`RS_DEPTH];
  logic [`RS_DEPTH-1:0] busy;
  logic [`RS_DEPTH-1:0] rdy_vec;   // busy with both sources ready
  logic [idx_w-1:0]     free_idx;
  logic [idx_w-1:0]     rdy_idx;
  logic                 do_dispatch;
  logic                 do_issue;

  assign rs_free     = ~&busy;
  assign do_dispatch = dispatch_valid && rs_free;
  assign do_issue    = !fu_busy && |rdy_vec;

  always_comb begin
    free_idx = '0;
    rdy_idx  = '0;
    for (int e = `RS_DEPTH - 1; e >= 0; e--) begin  // walk down so the lowest index wins
      rdy_vec[e] = busy[e] && ent[e].rdy_i && ent[e].rdy_j;
      if (!busy[e]) free_idx = idx_w'(e);
      if (rdy_vec[e]) rdy_idx = idx_w'(e);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy        <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= do_issue;
      if (do_issue) busy[rdy_idx] <= 1'b0;  // freed as it leaves
      if (do_dispatch) busy[free_idx] <= 1'b1;
    end
  end

  // operand capture from the cdb, then the new entry
  always_ff @(posedge clk_in) begin
    for (int e = 0; e < `RS_DEPTH; e++) begin
      if (busy[e] && cdb.valid && !ent[e].rdy_i && ent[e].tag_i == cdb.tag) begin
        ent[e].rdy_i <= 1'b1;
        ent[e].val_i <= cdb.value;
      end
      if (busy[e] && cdb.valid && !ent[e].rdy_j && ent[e].tag_j == cdb.tag) begin
        ent[e].rdy_j <= 1'b1;
        ent[e].val_j <= cdb.value;
      end
    end
    if (do_dispatch) ent[free_idx] <= dispatch;  // packet already carries this cycle's cdb
  end

  always_ff @(posedge clk_in) begin
    if (do_issue) begin
      issue.op    <= ent[rdy_idx].op;
      issue.tag   <= ent[rdy_idx].tag;
      issue.val_i <= ent[rdy_idx].val_i;
      issue.val_j <= ent[rdy_idx].val_j;
    end
  end

  // the issued entry was busy with both sources ready while the alu was free
  a_issue_ready: assert property (@(posedge clk_in) disable iff (rst_in)
    issue_valid |-> $past(busy[rdy_idx] && ent[rdy_idx].rdy_i && ent[rdy_idx].rdy_j
                          && !fu_busy));

  // a new instruction only lands in an entry that is free
  a_no_full_dispatch: assert property (@(posedge clk_in) disable iff (rst_in)
    dispatch_valid && rs_free |-> !busy[free_idx]);

endmodule

/* verilog/wb_host_port.sv */
`timescale 1ns/1ps
`include "rs_config.svh"

module wb_host_port
  import alu_ops_pkg::*;
  import rs_types_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [`WB_AW-1:0] wb_adr,
  input  logic [`XLEN-1:0]  wb_dat_w,
  output logic [`XLEN-1:0]  wb_dat_r,
  output logic              wb_ack,
  input  logic              rs_free,
  input  tag_lookup_t       lookup_i,
  input  tag_lookup_t       lookup_j,
  output logic [`TAG_W-1:0] lookup_tag_i,
  output logic [`TAG_W-1:0] lookup_tag_j,
  input  cdb_t              cdb,
  output logic              dispatch_valid,
  output dispatch_t         dispatch,
  output logic [`TAG_W-1:0] read_tag,
  input  tag_lookup_t       read_result,
  output logic              read_free
);

  localparam logic [`WB_AW-1:0] adr_val_i  = `WB_AW'(0);
  localparam logic [`WB_AW-1:0] adr_val_j  = `WB_AW'(1);
  localparam logic [`WB_AW-1:0] adr_issue  = `WB_AW'(2);
  localparam logic [`WB_AW-1:0] adr_sel    = `WB_AW'(3);
  localparam logic [`WB_AW-1:0] adr_result = `WB_AW'(4);
  localparam logic [`WB_AW-1:0] adr_done   = `WB_AW'(5);

  logic [`XLEN-1:0]  val_i_q;
  logic [`XLEN-1:0]  val_j_q;
  logic [`TAG_W-1:0] sel_tag;
  logic              req;
  logic              accept;
  tag_lookup_t       src_i;
  tag_lookup_t       src_j;

  // a literal source is taken as is, a pending one may already be resolved
  function automatic tag_lookup_t resolve_src(input logic rdy, input logic [`TAG_W-1:0] tag,
                                               input logic [`XLEN-1:0] val,
                                               input tag_lookup_t lk, input cdb_t bus);
    tag_lookup_t res;
    res.done  = 1'b1;
    res.value = val;
    if (!rdy) begin
      if (bus.valid && bus.tag == tag) res.value = bus.value;  // broadcast this cycle
      else if (lk.done) res.value = lk.value;
      else res.done = 1'b0;
    end
    return res;
  endfunction

  assign req            = wb_cyc && wb_stb && !wb_ack;  // ack ends the request
  assign dispatch_valid = req && wb_we && wb_adr == adr_issue;
  assign accept         = req && (!dispatch_valid || rs_free);  // full station stalls the bus
  assign read_free      = req && !wb_we && wb_adr == adr_result && read_result.done;
  assign read_tag       = sel_tag;
  assign lookup_tag_i   = wb_dat_w[10:8];
  assign lookup_tag_j   = wb_dat_w[14:12];

  always_comb begin
    src_i          = resolve_src(wb_dat_w[11], wb_dat_w[10:8], val_i_q, lookup_i, cdb);
    src_j          = resolve_src(wb_dat_w[15], wb_dat_w[14:12], val_j_q, lookup_j, cdb);
    dispatch.op    = alu_op_e'(wb_dat_w[3:0]);
    dispatch.tag   = wb_dat_w[6:4];
    dispatch.tag_i = wb_dat_w[10:8];
    dispatch.rdy_i = src_i.done;
    dispatch.val_i = src_i.value;
    dispatch.tag_j = wb_dat_w[14:12];
    dispatch.rdy_j = src_j.done;
    dispatch.val_j = src_j.value;
  end

  always_ff @(posedge clk_in) begin
    if (accept && wb_we) begin
      case (wb_adr)
        adr_val_i: val_i_q <= wb_dat_w;
        adr_val_j: val_j_q <= wb_dat_w;
        adr_sel:   sel_tag <= wb_dat_w[`TAG_W-1:0];
        default:   ;
      endcase
    end
    if (accept && !wb_we) begin
      case (wb_adr)
        adr_result: wb_dat_r <= read_result.value;
        adr_done:   wb_dat_r <= {{(`XLEN-1){1'b0}}, read_result.done};
        default:    wb_dat_r <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) wb_ack <= 1'b0;
    else wb_ack <= accept;
  end

  // a write held off by a full station stays on the bus until acked
  a_stall_held: assert property (@(posedge clk_in) disable iff (rst_in)
    req && !accept |=> req && $stable(wb_we) && $stable(wb_adr) && $stable(wb_dat_w));

endmodule

/* verilog/rs_types_pkg.sv */
`include "rs_config.svh"

package rs_types_pkg;
  import alu_ops_pkg::*;

  typedef struct packed {
    alu_op_e             op;
    logic [`TAG_W-1:0]   tag;    // destination rob tag
    logic                rdy_i;
    logic [`TAG_W-1:0]   tag_i;  // producer tag while not ready
    logic [`XLEN-1:0]    val_i;
    logic                rdy_j;
    logic [`TAG_W-1:0]   tag_j;
    logic [`XLEN-1:0]    val_j;
  } dispatch_t;

  typedef struct packed {
    alu_op_e             op;
    logic [`TAG_W-1:0]   tag;
    logic [`XLEN-1:0]    val_i;
    logic [`XLEN-1:0]    val_j;
  } issue_t;

  typedef struct packed {
    logic                valid;
    logic [`TAG_W-1:0]   tag;
    logic [`XLEN-1:0]    value;
  } cdb_t;

  typedef struct packed {
    logic                done;
    logic [`XLEN-1:0]    value;
  } tag_lookup_t;

endpackage

/* verilog/alu_ops_pkg.sv */
package alu_ops_pkg;

  // encoding matches bits 3:0 of the issue word from the host
  typedef enum logic [3:0] {
    add    = 4'd0,
    sub    = 4'd1,
    and_op = 4'd2,
    or_op  = 4'd3,
    xor_op = 4'd4,
    slt    = 4'd5,  // signed compare
    sltu   = 4'd6,  // unsigned compare
    sll    = 4'd7,
    srl    = 4'd8,
    sra    = 4'd9
  } alu_op_e;

  typedef enum logic {
    idle     = 1'b0,
    shifting = 1'b1  // serial shifter moving one bit per cycle
  } shift_state_e;

endpackage

/* include/rs_config.svh */
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// reservation station and reorder buffer sizing
`define RS_DEPTH 3
`define ROB_TAGS 8
`define TAG_W    3

`define XLEN     32
`define WB_AW    4  // word address bits on the host bus

`endif
